// File: vlog.f
common/vnarrow_pkg.sv
narrow/narrow_shifter.sv
narrow/narrow_enables.sv
verilog/beat_packer.sv
verilog/vnarrow_top.sv
verification/vnarrow_checker.sv
verification/vnarrow_tb.sv

// File: Makefile
# Verilator build and run for the vector narrowing unit.

VERILATOR ?= verilator
TOP       ?= vnarrow_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/vnarrow_tb.sv
`timescale 1ns/1ps

module vnarrow_tb;

	localparam int CLK_PERIOD      = 10;
	localparam int RESET_CYCLES    = 8;
	localparam int PLANNED_BEATS   = 73;
	localparam int WATCHDOG_CYCLES = 20 * PLANNED_BEATS + RESET_CYCLES + 200;
	localparam int WAIT_LIMIT      = 20; // cycles to wait for the last word.

	logic                     clk;
	logic                     rst;
	vnarrow_pkg::narrow_req_t req;
	logic                     out_valid;
	vnarrow_pkg::pack_out_t   out;
	logic                     drain;
	int                       chk_errors;
	int                       chk_words;

	logic [15:0] lfsr;
	int          tb_errors;
	int          tests_run;
	int          tests_failed;
	int          start_errors;
	int          start_words;

	vnarrow_top u_vnarrow_top (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.out_valid (out_valid),
		.out       (out)
	);

	vnarrow_checker u_checker (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.out_valid (out_valid),
		.out       (out),
		.drain     (drain),
		.errors    (chk_errors),
		.words     (chk_words)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	// ========================================================================
	// helpers
	// ========================================================================

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit.
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	function automatic logic [63:0] sign_bits(input int w);
		logic [63:0] m;
		m = '0;
		for (int b = w - 1; b < vnarrow_pkg::VEC_BITS; b += w) begin
			m[b] = 1'b1;
		end
		return m;
	endfunction

	function automatic vnarrow_pkg::sew_e sew_of(input int idx);
		case (idx)
			1:       return vnarrow_pkg::SEW16;
			2:       return vnarrow_pkg::SEW32;
			default: return vnarrow_pkg::SEW64;
		endcase
	endfunction

	task automatic send_beat(input vnarrow_pkg::sew_e sew, input logic arith, input int shamt,
		input logic [63:0] data, input logic [7:0] be);
		@(posedge clk);
		#1;
		req = '0;
		req.valid = 1'b1;
		req.sew = sew;
		req.arith = arith;
		req.shamt = shamt[vnarrow_pkg::SHAMT_BITS-1:0];
		req.data = data;
		req.be = be;
	endtask

	task automatic send_flush();
		@(posedge clk);
		#1;
		req = '0;
		req.flush = 1'b1;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic start_test();
		start_errors = chk_errors + tb_errors;
		start_words = chk_words;
	endtask

	task automatic finish_test(input string name, input int want_words);
		int waited;
		drive_idle();
		waited = 0;
		while (chk_words < start_words + want_words && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (chk_words < start_words + want_words) begin
			$display("test %s: timed out waiting for output words", name);
			tb_errors++;
		end
		repeat (4) @(posedge clk); // room for a stray word.
		#1;
		if (chk_words != start_words + want_words) begin
			$display("test %s: got %0d words, expected %0d", name,
				chk_words - start_words, want_words);
			tb_errors++;
		end
		tests_run++;
		if (chk_errors + tb_errors == start_errors) begin
			$display("test %-8s ok, %0d words", name, want_words);
		end else begin
			tests_failed++;
			$display("test %-8s failed, %0d errors", name,
				chk_errors + tb_errors - start_errors);
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		logic [63:0] r;
		logic [63:0] s;
		int          ew;
		int          sh;
		req = '0;
		rst = 1'b1;
		drain = 1'b0;
		lfsr = 16'd65;
		tb_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;

		// nothing comes out until a pair is complete.
		start_test();
		repeat (3) drive_idle();
		send_beat(vnarrow_pkg::SEW32, 1'b0, 5, rand_bits(64), 8'hff);
		repeat (4) drive_idle();
		send_beat(vnarrow_pkg::SEW32, 1'b0, 9, rand_bits(64), 8'hff);
		finish_test("reset", 1);

		start_test();
		for (int w = 1; w <= 3; w++) begin
			for (int b = 0; b < 8; b++) begin
				r = rand_bits(64);
				s = rand_bits(6);
				send_beat(sew_of(w), 1'b0, int'(s[5:0]), r, 8'hff);
			end
		end
		finish_test("logical", 12);

		// negative elements with shifts at and past the element width.
		start_test();
		for (int w = 1; w <= 3; w++) begin
			ew = 8 << w;
			for (int b = 0; b < 4; b++) begin
				r = rand_bits(64) | sign_bits(ew);
				case (b)
					0: sh = ew - 1;
					1: sh = ew;
					2: sh = ew + 3;
					default: begin
						s = rand_bits(6);
						sh = int'(s[5:0]);
					end
				endcase
				send_beat(sew_of(w), 1'b1, sh, r, 8'hff);
			end
		end
		finish_test("arith", 6);

		start_test();
		for (int w = 1; w <= 3; w++) begin
			for (int b = 0; b < 4; b++) begin
				r = rand_bits(64);
				s = rand_bits(15);
				send_beat(sew_of(w), s[14], int'(s[13:8]), r, s[7:0]);
			end
		end
		finish_test("enables", 6);

		start_test();
		for (int w = 1; w <= 3; w++) begin
			r = rand_bits(64);
			s = rand_bits(15);
			send_beat(sew_of(w), s[14], int'(s[13:8]), r, s[7:0]);
			send_flush();
		end
		drive_idle();
		send_flush(); // nothing held here.
		finish_test("flush", 3);

		// back to back pairs with the latency checked per word.
		start_test();
		for (int p = 0; p < 8; p++) begin
			s = rand_bits(2);
			ew = 1 + int'(s[1:0]) % 3;
			for (int b = 0; b < 2; b++) begin
				r = rand_bits(64);
				s = rand_bits(15);
				send_beat(sew_of(ew), s[14], int'(s[13:8]), r, s[7:0]);
			end
		end
		finish_test("stream", 8);

		drain = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		$display("tests run %0d, failed %0d, errors %0d, words checked %0d",
			tests_run, tests_failed, chk_errors + tb_errors, chk_words);
		if (chk_errors + tb_errors == 0 && tests_failed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: verification/vnarrow_checker.sv
`timescale 1ns/1ps

module vnarrow_checker (
	input  logic                     clk,
	input  logic                     rst,
	input  vnarrow_pkg::narrow_req_t req,
	input  logic                     out_valid,
	input  vnarrow_pkg::pack_out_t   out,
	input  logic                     drain,
	output int                       errors,
	output int                       words
);

	typedef struct packed {
		logic [vnarrow_pkg::HALF_BITS-1:0] half;
		logic [vnarrow_pkg::BE_BITS/2-1:0] be;
	} half_beat_t;

	vnarrow_pkg::pack_out_t exp_q[$];
	int                     due_q[$];
	half_beat_t             held;
	half_beat_t             cur;
	vnarrow_pkg::sew_e      held_sew;
	logic                   held_valid;
	logic                   drain_done;
	vnarrow_pkg::pack_out_t want;
	int                     due;
	int                     cycle;

	// ========================================================================
	// reference model
	// ========================================================================

	// result bit i takes source bit i+s or the fill past the top.
	function automatic half_beat_t narrow_ref(input vnarrow_pkg::narrow_req_t r);
		half_beat_t res;
		int         w;
		int         s;
		logic       fill;
		res = '0;
		w = 8 << int'(r.sew); // SEW16 gives 16.
		s = int'(r.shamt) % w;
		for (int e = 0; e < vnarrow_pkg::VEC_BITS / w; e++) begin
			fill = r.arith & r.data[e*w + w - 1];
			for (int i = 0; i < w / 2; i++) begin
				if (i + s < w) begin
					res.half[e*(w/2) + i] = r.data[e*w + i + s];
				end else begin
					res.half[e*(w/2) + i] = fill;
				end
			end
			// low half-bytes of the element.
			for (int k = 0; k < w / 16; k++) begin
				res.be[e*(w/16) + k] = r.be[e*(w/8) + k];
			end
		end
		return res;
	endfunction

	function automatic vnarrow_pkg::sew_e dst_of(input vnarrow_pkg::sew_e src);
		case (src)
			vnarrow_pkg::SEW64: return vnarrow_pkg::SEW32;
			vnarrow_pkg::SEW32: return vnarrow_pkg::SEW16;
			default:            return vnarrow_pkg::SEW8;
		endcase
	endfunction

	// ========================================================================
	// pairing and compare
	// ========================================================================

	initial begin
		errors = 0;
		words = 0;
		cycle = 0;
		held_valid = 1'b0;
		drain_done = 1'b0;
		forever begin
			@(posedge clk);
			cycle++;
			if (out_valid === 1'b1) begin
				if (rst || exp_q.size() == 0) begin
					$display("%0d ns: out_valid high with no word expected", $time);
					errors++;
				end else begin
					want = exp_q.pop_front();
					due = due_q.pop_front();
					words++;
					if (cycle != due) begin
						$display("%0d ns: word came at cycle %0d, expected at cycle %0d",
							$time, cycle, due);
						errors++;
					end
					if (out.data !== want.data) begin
						$display("** Error at %0d ns: out.data = %h, expected %h",
							$time, out.data, want.data);
						errors++;
					end
					if (out.be !== want.be) begin
						$display("** Error at %0d ns: out.be = %h, expected %h",
							$time, out.be, want.be);
						errors++;
					end
					if (out.sew !== want.sew) begin
						$display("** Error at %0d ns: out.sew = %0d, expected %0d",
							$time, out.sew, want.sew);
						errors++;
					end
				end
			end else if (out_valid !== 1'b0 && !rst) begin
				$display("%0d ns: out_valid is unknown after reset", $time);
				errors++;
			end

			if (rst) begin
				held_valid = 1'b0;
				exp_q.delete();
				due_q.delete();
			end else if (req.valid) begin
				cur = narrow_ref(req);
				if (held_valid) begin
					want.data = {cur.half, held.half}; // first beat low.
					want.be = {cur.be, held.be};
					want.sew = dst_of(held_sew);
					exp_q.push_back(want);
					due_q.push_back(cycle + 2);
					held_valid = 1'b0;
				end else begin
					held = cur;
					held_sew = req.sew;
					held_valid = 1'b1;
				end
			end else if (req.flush && held_valid) begin
				want.data = {{vnarrow_pkg::HALF_BITS{1'b0}}, held.half};
				want.be = {{(vnarrow_pkg::BE_BITS/2){1'b0}}, held.be};
				want.sew = dst_of(held_sew);
				exp_q.push_back(want);
				due_q.push_back(cycle + 2);
				held_valid = 1'b0;
			end

			if (drain && !drain_done) begin
				drain_done = 1'b1;
				if (exp_q.size() != 0) begin
					$display("%0d expected words never came out", exp_q.size());
					errors++;
				end
			end
		end
	end

endmodule

// File: verilog/vnarrow_top.sv
`timescale 1ns/1ps

module vnarrow_top (
	input  logic                     clk,
	input  logic                     rst,
	input  vnarrow_pkg::narrow_req_t req,
	output logic                     out_valid,
	output vnarrow_pkg::pack_out_t   out
);

	// both narrowers register on the same edge, so half and ctl stay aligned.
	logic [vnarrow_pkg::HALF_BITS-1:0] half;
	vnarrow_pkg::narrow_ctl_t          ctl;

	// ========================================================================
	// narrowing stage
	// ========================================================================

	narrow_shifter u_narrow_shifter (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.half (half)
	);

	narrow_enables u_narrow_enables (
		.clk (clk),
		.rst (rst),
		.req (req),
		.ctl (ctl)
	);

	// ========================================================================
	// packing stage
	// ========================================================================

	beat_packer u_beat_packer (
		.clk       (clk),
		.rst       (rst),
		.half      (half),
		.ctl       (ctl),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

// File: verilog/beat_packer.sv
`timescale 1ns/1ps

module beat_packer (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [vnarrow_pkg::HALF_BITS-1:0] half,
	input  vnarrow_pkg::narrow_ctl_t          ctl,
	output logic                              out_valid,
	output vnarrow_pkg::pack_out_t            out
);

	logic                                turn;      // a first beat is held.
	logic [vnarrow_pkg::HALF_BITS-1:0]   held_half;
	logic [vnarrow_pkg::BE_BITS/2-1:0]   held_be;
	vnarrow_pkg::sew_e                   held_sew;

	logic                                emit;
	logic [vnarrow_pkg::HALF_BITS-1:0]   high_half;
	logic [vnarrow_pkg::BE_BITS/2-1:0]   high_be;
	vnarrow_pkg::sew_e                   dst_sew;

	// ========================================================================
	// word assembly
	// ========================================================================

	// second beat or flush closes the pair, lone flush does nothing.
	assign emit = turn & (ctl.valid | ctl.flush);

	// flush leaves the high half empty.
	assign high_half = ctl.valid ? half : '0;
	assign high_be   = ctl.valid ? ctl.be : '0;

	assign dst_sew = vnarrow_pkg::sew_e'(held_sew - 2'd1); // one step down.

	// ========================================================================
	// pairing state and output register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			turn      <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= emit;
			if (emit) begin
				turn <= 1'b0;
			end else if (ctl.valid) begin
				turn <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctl.valid && !turn) begin
			held_half <= half;
			held_be   <= ctl.be;
			held_sew  <= ctl.sew;
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			out.data <= {high_half, held_half}; // first beat low.
			out.be   <= {high_be, held_be};
			out.sew  <= dst_sew;
		end
	end

	// the word carries one width, so both halves must agree.
	a_pair_same_sew : assert property (
		@(posedge clk) disable iff (rst)
		(turn && ctl.valid) |-> ctl.sew == held_sew
	);

endmodule

// File: narrow/narrow_enables.sv
`timescale 1ns/1ps

module narrow_enables (
	input  logic                     clk,
	input  logic                     rst,
	input  vnarrow_pkg::narrow_req_t req,
	output vnarrow_pkg::narrow_ctl_t ctl
);

	logic [vnarrow_pkg::BE_BITS/2-1:0] be_next;

	// keep the enables of the low half of each source element.
	always_comb begin
		case (req.sew)
			vnarrow_pkg::SEW16: be_next = {req.be[6], req.be[4], req.be[2], req.be[0]};
			vnarrow_pkg::SEW32: be_next = {req.be[5], req.be[4], req.be[1], req.be[0]};
			vnarrow_pkg::SEW64: be_next = req.be[3:0];
			default:            be_next = '0;
		endcase
	end

	// ========================================================================
	// beat control stage
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			ctl.valid <= 1'b0;
			ctl.flush <= 1'b0;
		end else begin
			ctl.valid <= req.valid;
			ctl.flush <= req.flush;
		end
	end

	// payload follows the same edge as the shifter output.
	always_ff @(posedge clk) begin
		if (req.valid) begin
			ctl.sew <= req.sew;
			ctl.be  <= be_next;
		end
	end

	// flush shares the pairing state with valid beats downstream.
	a_valid_flush_excl : assert property (
		@(posedge clk) disable iff (rst)
		!(req.valid && req.flush)
	);

endmodule

// File: narrow/narrow_shifter.sv
`timescale 1ns/1ps

module narrow_shifter (
	input  logic                                clk,
	input  logic                                rst,
	input  vnarrow_pkg::narrow_req_t            req,
	output logic [vnarrow_pkg::HALF_BITS-1:0]   half
);

	// one candidate per source width: 16, 32 and 64 bits.
	logic [2:0][vnarrow_pkg::HALF_BITS-1:0] cand;
	logic [vnarrow_pkg::HALF_BITS-1:0]      half_next;

	// ========================================================================
	// per-element shift and halve
	// ========================================================================

	// w selects the source width as 16 << w.
	for (genvar w = 0; w < 3; w++) begin : g_sew
		for (genvar e = 0; e < (vnarrow_pkg::VEC_BITS >> (4 + w)); e++) begin : g_elem
			logic [(16 << w)-1:0] src;
			logic [(32 << w)-1:0] ext;
			logic [3+w:0]         sh;

			assign src = req.data[e*(16 << w) +: (16 << w)];
			// upper half is the fill, so a plain right select acts as sra/srl.
			assign ext = {{(16 << w){req.arith & src[(16 << w)-1]}}, src};
			assign sh  = req.shamt[3+w:0]; // modulo element width.

			assign cand[w][e*(8 << w) +: (8 << w)] = ext[sh +: (8 << w)];
		end
	end

	always_comb begin
		case (req.sew)
			vnarrow_pkg::SEW16: half_next = cand[0];
			vnarrow_pkg::SEW32: half_next = cand[1];
			vnarrow_pkg::SEW64: half_next = cand[2];
			default:            half_next = '0; // 8-bit source not supported.
		endcase
	end

	// ========================================================================
	// output register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (req.valid) begin
			half <= half_next;
		end
	end

	// packer has no 8-bit path, a byte source would give a bogus width.
	a_no_sew8 : assert property (
		@(posedge clk) disable iff (rst)
		req.valid |-> req.sew != vnarrow_pkg::SEW8
	);

endmodule

// File: common/vnarrow_pkg.sv
package vnarrow_pkg;

	// ========================================================================
	// datapath widths
	// ========================================================================

	localparam int VEC_BITS   = 64; // full vector word.
	localparam int HALF_BITS  = 32; // one narrowed beat.
	localparam int BE_BITS    = 8;  // byte enables per word.
	localparam int SHAMT_BITS = 6;  // enough for 64-bit elements.

	// element width, source is one step above destination.
	typedef enum logic [1:0] {
		SEW8  = 2'd0,
		SEW16 = 2'd1,
		SEW32 = 2'd2,
		SEW64 = 2'd3
	} sew_e;

	// ========================================================================
	// beat structs
	// ========================================================================

	// input beat, flush travels on its own cycle.
	typedef struct packed {
		logic                  valid;
		logic                  flush;
		sew_e                  sew;   // source width.
		logic                  arith; // sign fill when set.
		logic [SHAMT_BITS-1:0] shamt;
		logic [VEC_BITS-1:0]   data;
		logic [BE_BITS-1:0]    be;
	} narrow_req_t;

	// enable stage result, lines up with the narrowed half.
	typedef struct packed {
		logic                  valid;
		logic                  flush;
		sew_e                  sew;
		logic [BE_BITS/2-1:0]  be;    // compacted enables.
	} narrow_ctl_t;

	// packed output word.
	typedef struct packed {
		logic [VEC_BITS-1:0]   data;
		logic [BE_BITS-1:0]    be;
		sew_e                  sew;   // destination width.
	} pack_out_t;

endpackage
